/* common/rvviPkg.sv */
`default_nettype none

package rvviPkg;

   ///////////////////////////////////////////////////////////////////////
   // widths and counts
   ///////////////////////////////////////////////////////////////////////
   localparam int xlen      = 32;
   localparam int numCsr    = 8;
   localparam int numGpr    = 32;
   localparam int numNet    = 10;
   localparam int numIrqNet = 7;

   ///////////////////////////////////////////////////////////////////////
   // CSR slots
   ///////////////////////////////////////////////////////////////////////
   typedef enum logic [2:0] {
      csrMstatus,
      csrMie,
      csrMtvec,
      csrMscratch,
      csrMepc,
      csrMcause,
      csrMtval,
      csrMip
   } csrIdx_e;

   // architectural address per slot, same order as csrIdx_e
   localparam logic [11:0] csrAddr [numCsr] = '{
      12'h300, 12'h304, 12'h305, 12'h340,
      12'h341, 12'h342, 12'h343, 12'h344
   };

   ///////////////////////////////////////////////////////////////////////
   // nets and causes
   ///////////////////////////////////////////////////////////////////////
   // lowest value wins when several nets change together
   typedef enum logic [3:0] {
      haltReq,
      mswIrq,
      mTimerIrq,
      mExtIrq,
      localIrq0,
      localIrq1,
      localIrq2,
      localIrq3,
      nmi,
      instrBusFault
   } netId_e;

   // core irq line for each interrupt net, starting at mswIrq
   localparam int unsigned irqLineOf [numIrqNet] = '{3, 7, 11, 16, 17, 18, 19};

   localparam logic [10:0] nmiLoadCause       = 11'd1024;
   localparam logic [10:0] nmiStoreCause      = 11'd1025;
   localparam logic [5:0]  instrBusFaultCause = 6'd48;

   ///////////////////////////////////////////////////////////////////////
   // records
   ///////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic [xlen-1:0] rdata;
      logic [xlen-1:0] wdata;
      logic [xlen-1:0] wmask;
   } csrPort_t;

   typedef struct packed {
      logic       trap;
      logic       exception;
      logic [5:0] exceptionCause;
   } trapInfo_t;

   typedef struct packed {
      logic        intr;
      logic        interrupt;
      logic [10:0] cause;
   } intrInfo_t;

   // one retired instruction as seen on the core side
   typedef struct packed {
      logic [63:0]                order;
      logic [31:0]                insn;
      trapInfo_t                  trap;
      intrInfo_t                  intr;
      logic                       nmiPending;
      logic [1:0]                 mode;
      logic [xlen-1:0]            pcRdata;
      logic [xlen-1:0]            pcWdata;
      logic [4:0]                 rdAddr;
      logic [xlen-1:0]            rdWdata;
      csrPort_t [numCsr-1:0]      csr;
   } retire_t;

   typedef struct packed {
      logic [63:0]                order;
      logic [31:0]                insn;
      trapInfo_t                  trap;
      intrInfo_t                  intr;
      logic [1:0]                 mode;
      logic [xlen-1:0]            pcRdata;
      logic [xlen-1:0]            pcWdata;
      logic [numGpr-1:0]          xWb;
      logic [xlen-1:0]            xWdata;
      logic [numCsr-1:0][xlen-1:0] csr;
      logic [numCsr-1:0]          csrWb;
   } trace_t;

   typedef struct packed {
      netId_e id;
      logic   level;
      logic   nmiStore;
   } netEvent_t;

endpackage

`default_nettype wire

/* design/retireFormatter.sv */
`timescale 1ns/10ps
`default_nettype none

module retireFormatter (
   input  wire logic               rvvi,
   input  wire logic               rstN_i,
   input  wire logic               retValid_i,
   input  wire rvviPkg::retire_t   ret_i,
   input  wire logic               traceReady_i,
   output logic                    retReady_o,
   output logic                    traceValid_o,
   output rvviPkg::trace_t         trace_o
);

   logic                                           accept;
   rvviPkg::trace_t                                nextTrace;
   logic [rvviPkg::numCsr-1:0][rvviPkg::xlen-1:0]  prevCsr;

   // single slot, so a taken record frees it in the same cycle
   assign retReady_o = !traceValid_o || traceReady_i;
   assign accept     = retValid_i && retReady_o;

   //////////////////////////////////////////////////////////////////////
   // record formatting
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      nextTrace.order   = ret_i.order;
      nextTrace.insn    = ret_i.insn;
      nextTrace.trap    = ret_i.trap;
      nextTrace.intr    = ret_i.intr;
      nextTrace.mode    = ret_i.mode;
      nextTrace.pcRdata = ret_i.pcRdata;
      nextTrace.pcWdata = ret_i.pcWdata;

      // written bits from wdata, the rest from rdata
      for (int i = 0; i < rvviPkg::numCsr; i++) begin
         nextTrace.csr[i] = (ret_i.csr[i].wdata & ret_i.csr[i].wmask)
                          | (ret_i.csr[i].rdata & ~ret_i.csr[i].wmask);
         nextTrace.csrWb[i] = nextTrace.csr[i] != prevCsr[i];
      end

      // x0 never shows a writeback
      if (ret_i.rdAddr != 5'd0) begin
         nextTrace.xWb    = rvviPkg::numGpr'(1) << ret_i.rdAddr;
         nextTrace.xWdata = ret_i.rdWdata;
      end else begin
         nextTrace.xWb    = '0;
         nextTrace.xWdata = '0;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // output slot
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (!rstN_i) begin
         traceValid_o <= 1'b0;
         prevCsr      <= '0;
      end else if (accept) begin
         traceValid_o <= 1'b1;
         // reference for the next csrWb compare
         prevCsr      <= nextTrace.csr;
      end else if (traceReady_i) begin
         traceValid_o <= 1'b0;
      end
   end

   always_ff @(posedge rvvi) begin
      if (accept) begin
         trace_o <= nextTrace;
      end
   end

endmodule

`default_nettype wire

/* netTracker/netLatch.sv */
`timescale 1ns/10ps
`default_nettype none

module netLatch (
   input  wire logic                  rvvi,
   input  wire logic                  rstN_i,
   input  wire logic                  retFire_i,
   input  wire rvviPkg::retire_t      ret_i,
   input  wire logic [31:0]           irq_i,
   input  wire logic                  debugReq_i,
   output logic [rvviPkg::numNet-1:0] wanted_o,
   output logic                       nmiStore_o
);

   logic                        nmiCause;
   logic                        nmiSrc;
   logic                        busFaultSrc;
   logic [rvviPkg::numNet-1:0]  srcHit;

   //////////////////////////////////////////////////////////////////////
   // sources
   //////////////////////////////////////////////////////////////////////
   // load or store bus error reported as an interrupt
   assign nmiCause = ret_i.intr.intr && ret_i.intr.interrupt
                  && (ret_i.intr.cause == rvviPkg::nmiLoadCause
                      || ret_i.intr.cause == rvviPkg::nmiStoreCause);

   assign nmiSrc      = nmiCause || ret_i.nmiPending;
   assign busFaultSrc = ret_i.trap.trap && ret_i.trap.exception
                     && ret_i.trap.exceptionCause == rvviPkg::instrBusFaultCause;

   always_comb begin
      srcHit = '0;
      srcHit[rvviPkg::haltReq] = debugReq_i;
      for (int k = 0; k < rvviPkg::numIrqNet; k++) begin
         srcHit[int'(rvviPkg::mswIrq) + k] = irq_i[rvviPkg::irqLineOf[k]];
      end
      // retirement sourced nets only count on a transfer
      srcHit[rvviPkg::nmi]           = retFire_i && nmiSrc;
      srcHit[rvviPkg::instrBusFault] = retFire_i && busFaultSrc;
   end

   //////////////////////////////////////////////////////////////////////
   // wanted levels
   //////////////////////////////////////////////////////////////////////
   // set while the source is high, clear on a retirement without it
   always_ff @(posedge rvvi) begin
      if (!rstN_i) begin
         wanted_o   <= '0;
         nmiStore_o <= 1'b0;
      end else begin
         wanted_o <= srcHit | (wanted_o & ~{rvviPkg::numNet{retFire_i}});
         if (retFire_i && nmiSrc) begin
            nmiStore_o <= ret_i.intr.cause == rvviPkg::nmiStoreCause;
         end
      end
   end

endmodule

`default_nettype wire

/* netTracker/netReporter.sv */
`timescale 1ns/10ps
`default_nettype none

module netReporter (
   input  wire logic                  rvvi,
   input  wire logic                  rstN_i,
   input  wire logic [rvviPkg::numNet-1:0] wanted_i,
   input  wire logic                  nmiStore_i,
   input  wire logic                  netReady_i,
   output logic                       netValid_o,
   output rvviPkg::netEvent_t         netEvent_o
);

   logic [rvviPkg::numNet-1:0]  reported;
   logic [rvviPkg::numNet-1:0]  diff;
   logic [3:0]                  pickIdx;

   // nets the consumer has not yet been told about
   assign diff       = wanted_i ^ reported;
   assign netValid_o = |diff;

   //////////////////////////////////////////////////////////////////////
   // priority select
   //////////////////////////////////////////////////////////////////////
   always_comb begin
      pickIdx = '0;
      // walk downwards so the lowest differing net is kept
      for (int n = rvviPkg::numNet - 1; n >= 0; n--) begin
         if (diff[n]) begin
            pickIdx = 4'(n);
         end
      end
   end

   always_comb begin
      netEvent_o.id       = rvviPkg::netId_e'(pickIdx);
      netEvent_o.level    = wanted_i[pickIdx];
      netEvent_o.nmiStore = (netEvent_o.id == rvviPkg::nmi) ? nmiStore_i : 1'b0;
   end

   //////////////////////////////////////////////////////////////////////
   // reported levels
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (!rstN_i) begin
         reported <= '0;
      end else if (netValid_o && netReady_i) begin
         reported[pickIdx] <= wanted_i[pickIdx];
      end
   end

endmodule

`default_nettype wire

/* design/rvfiRvviBridge.sv */
`timescale 1ns/10ps
`default_nettype none

module rvfiRvviBridge (
   input  wire logic               rvvi,
   input  wire logic               rstN_i,
   input  wire logic               retValid_i,
   input  wire rvviPkg::retire_t   ret_i,
   input  wire logic               traceReady_i,
   input  wire logic [31:0]        irq_i,
   input  wire logic               debugReq_i,
   input  wire logic               netReady_i,
   output logic                    retReady_o,
   output logic                    traceValid_o,
   output rvviPkg::trace_t         trace_o,
   output logic                    netValid_o,
   output rvviPkg::netEvent_t      netEvent_o
);

   logic                        retFire;
   logic [rvviPkg::numNet-1:0]  wanted;
   logic                        nmiStore;

   // retirement handshake completes this edge
   assign retFire = retValid_i && retReady_o;

   retireFormatter uFormatter (
      .rvvi         (rvvi),
      .rstN_i       (rstN_i),
      .retValid_i   (retValid_i),
      .ret_i        (ret_i),
      .traceReady_i (traceReady_i),
      .retReady_o   (retReady_o),
      .traceValid_o (traceValid_o),
      .trace_o      (trace_o)
   );

   netLatch uNetLatch (
      .rvvi       (rvvi),
      .rstN_i     (rstN_i),
      .retFire_i  (retFire),
      .ret_i      (ret_i),
      .irq_i      (irq_i),
      .debugReq_i (debugReq_i),
      .wanted_o   (wanted),
      .nmiStore_o (nmiStore)
   );

   netReporter uNetReporter (
      .rvvi       (rvvi),
      .rstN_i     (rstN_i),
      .wanted_i   (wanted),
      .nmiStore_i (nmiStore),
      .netReady_i (netReady_i),
      .netValid_o (netValid_o),
      .netEvent_o (netEvent_o)
   );

endmodule

`default_nettype wire

/* dv/tbModel.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// expected trace records, the head is the one held on trace_o
rvviPkg::trace_t              expQ[$];
logic [rvviPkg::xlen-1:0]     modelPrevCsr [rvviPkg::numCsr];
logic [rvviPkg::numNet-1:0]   modelWanted;
logic [rvviPkg::numNet-1:0]   modelReported;
logic                         modelNmiStore;

// bit by bit merge of one retirement into a trace record
function automatic rvviPkg::trace_t expectTrace(input rvviPkg::retire_t r);
   rvviPkg::trace_t t;
   t         = '0;
   t.order   = r.order;
   t.insn    = r.insn;
   t.trap    = r.trap;
   t.intr    = r.intr;
   t.mode    = r.mode;
   t.pcRdata = r.pcRdata;
   t.pcWdata = r.pcWdata;
   for (int c = 0; c < rvviPkg::numCsr; c++) begin
      for (int b = 0; b < rvviPkg::xlen; b++) begin
         t.csr[c][b] = r.csr[c].wmask[b] ? r.csr[c].wdata[b] : r.csr[c].rdata[b];
      end
      t.csrWb[c] = (t.csr[c] !== modelPrevCsr[c]);
   end
   // x0 is skipped on purpose
   for (int g = 1; g < rvviPkg::numGpr; g++) begin
      t.xWb[g] = (r.rdAddr == 5'(g));
   end
   t.xWdata = (r.rdAddr == 5'd0) ? '0 : r.rdWdata;
   return t;
endfunction

function automatic logic nmiSourced(input rvviPkg::retire_t r);
   logic causeHit;
   causeHit = (r.intr.cause == rvviPkg::nmiLoadCause)
           || (r.intr.cause == rvviPkg::nmiStoreCause);
   return (r.intr.intr && r.intr.interrupt && causeHit) || r.nmiPending;
endfunction

function automatic logic busFaultSourced(input rvviPkg::retire_t r);
   return r.trap.trap && r.trap.exception
       && (r.trap.exceptionCause == rvviPkg::instrBusFaultCause);
endfunction

// first net whose wanted level is not yet reported, -1 when none
function automatic int lowestDiff();
   for (int n = 0; n < rvviPkg::numNet; n++) begin
      if (modelWanted[n] != modelReported[n]) begin
         return n;
      end
   end
   return -1;
endfunction

function automatic rvviPkg::netEvent_t expectedNet();
   rvviPkg::netEvent_t e;
   int pick;
   pick       = lowestDiff();
   e.id       = rvviPkg::netId_e'(pick);
   e.level    = modelWanted[pick];
   e.nmiStore = (pick == int'(rvviPkg::nmi)) && modelNmiStore;
   return e;
endfunction

// one rising edge of the bridge
task automatic stepModel(input rvviPkg::retire_t r, input logic fireRet,
                         input logic fireTrace, input logic fireNet,
                         input logic [31:0] irqLines, input logic dbg);
   logic [rvviPkg::numNet-1:0] src;
   rvviPkg::trace_t            t;
   int                         pick;
   pick = lowestDiff();
   if (fireNet) begin
      modelReported[pick] = modelWanted[pick];
   end
   src = '0;
   src[rvviPkg::haltReq] = dbg;
   for (int k = 0; k < rvviPkg::numIrqNet; k++) begin
      src[int'(rvviPkg::mswIrq) + k] = irqLines[rvviPkg::irqLineOf[k]];
   end
   src[rvviPkg::nmi]           = fireRet && nmiSourced(r);
   src[rvviPkg::instrBusFault] = fireRet && busFaultSourced(r);
   if (src[rvviPkg::nmi]) begin
      modelNmiStore = (r.intr.cause == rvviPkg::nmiStoreCause);
   end
   // set on source, clear only on a retirement without it
   for (int n = 0; n < rvviPkg::numNet; n++) begin
      if (src[n]) begin
         modelWanted[n] = 1'b1;
      end else if (fireRet) begin
         modelWanted[n] = 1'b0;
      end
   end
   if (fireTrace) begin
      void'(expQ.pop_front());
   end
   if (fireRet) begin
      t = expectTrace(r);
      expQ.push_back(t);
      for (int c = 0; c < rvviPkg::numCsr; c++) begin
         modelPrevCsr[c] = t.csr[c];
      end
   end
endtask

`endif

/* dv/tbBridge.sv */
`timescale 1ns/10ps
`default_nettype none

module tbBridge;

   localparam int numRet    = 1500;
   // twice the number of retirements
   localparam int maxCycles = 2 * numRet;

   logic                rvvi;
   logic                rstN;
   logic                retValid;
   rvviPkg::retire_t    ret;
   logic                traceReady;
   logic [31:0]         irq;
   logic                debugReq;
   logic                netReady;
   logic                retReady;
   logic                traceValid;
   rvviPkg::trace_t     trace;
   logic                netValid;
   rvviPkg::netEvent_t  netEvent;

   logic [31:0]         rngState;
   logic [63:0]         nextOrder;
   logic                retFire;
   logic                traceFire;
   logic                netFire;
   int                  accepted;
   int                  cycles = 0;

   `include "tbModel.svh"

   rvfiRvviBridge u_dut (
      .rvvi         (rvvi),
      .rstN_i       (rstN),
      .retValid_i   (retValid),
      .ret_i        (ret),
      .traceReady_i (traceReady),
      .irq_i        (irq),
      .debugReq_i   (debugReq),
      .netReady_i   (netReady),
      .retReady_o   (retReady),
      .traceValid_o (traceValid),
      .trace_o      (trace),
      .netValid_o   (netValid),
      .netEvent_o   (netEvent)
   );

   initial begin
      rvvi = 1'b0;
      forever #20 rvvi = ~rvvi;
   end

   always @(posedge rvvi) begin
      cycles = cycles + 1;
      if (cycles >= maxCycles) begin
         $display("timeout: the run did not finish within %0d cycles", maxCycles);
         abortRun();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // checking
   //////////////////////////////////////////////////////////////////////
   task automatic abortRun();
      $display(">>> FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic checkFlag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got=%b exp=%b", $time, name, got, exp);
         abortRun();
      end
   endtask

   task automatic checkTrace(input string name, input rvviPkg::trace_t got,
                             input rvviPkg::trace_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got=%h exp=%h", $time, name, got, exp);
         abortRun();
      end
   endtask

   task automatic checkNet(input string name, input rvviPkg::netEvent_t got,
                           input rvviPkg::netEvent_t exp);
      if (got !== exp) begin
         $display("FAIL %0t %s got=%h exp=%h", $time, name, got, exp);
         abortRun();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////
   function automatic logic [31:0] nextRand();
      logic [31:0] x;
      x = rngState;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rngState = x;
      return x;
   endfunction

   task automatic makeRetire();
      logic [31:0] pick;
      logic [31:0] sel;
      pick                     = nextRand();
      ret.order                = nextOrder;
      nextOrder                = nextOrder + 1;
      ret.insn                 = nextRand();
      ret.trap.trap            = pick[0];
      ret.trap.exception       = pick[1];
      ret.intr.intr            = pick[2];
      ret.intr.interrupt       = pick[3];
      ret.nmiPending           = (pick[7:4] == 4'd0);
      ret.mode                 = pick[9:8];
      ret.rdAddr               = (pick[12:10] == 3'd0) ? 5'd0 : pick[17:13];
      ret.rdWdata              = nextRand();
      ret.pcRdata              = nextRand();
      ret.pcWdata              = nextRand();
      ret.trap.exceptionCause  = (nextRand() % 10 == 0) ? rvviPkg::instrBusFaultCause
                                                        : 6'(nextRand());
      sel = nextRand() % 10;
      if (sel == 0) begin
         ret.intr.cause = rvviPkg::nmiLoadCause;
      end else if (sel == 1) begin
         ret.intr.cause = rvviPkg::nmiStoreCause;
      end else begin
         ret.intr.cause = 11'(nextRand());
      end
      for (int c = 0; c < rvviPkg::numCsr; c++) begin
         pick = nextRand();
         // sometimes repeat the last value so csrWb stays low
         if (pick[1:0] == 2'd0) begin
            ret.csr[c].rdata = modelPrevCsr[c];
            ret.csr[c].wdata = nextRand();
            ret.csr[c].wmask = '0;
         end else begin
            ret.csr[c].rdata = nextRand();
            ret.csr[c].wdata = nextRand();
            ret.csr[c].wmask = nextRand();
         end
      end
   endtask

   task automatic driveInputs();
      int line;
      // valid and the record hold until the transfer
      if (retFire || !retValid) begin
         if (accepted < numRet && nextRand() % 16 != 0) begin
            makeRetire();
            retValid = 1'b1;
         end else begin
            retValid = 1'b0;
         end
      end
      if (accepted < numRet) begin
         traceReady = (nextRand() % 10) < 7;
         netReady   = (nextRand() % 10) < 7;
         if (nextRand() % 8 == 0) begin
            line      = rvviPkg::irqLineOf[nextRand() % rvviPkg::numIrqNet];
            irq[line] = ~irq[line];
         end
         if (nextRand() % 64 == 0) begin
            line      = nextRand() % 32;
            irq[line] = ~irq[line];
         end
         if (nextRand() % 32 == 0) begin
            debugReq = ~debugReq;
         end
      end else begin
         // drain
         traceReady = 1'b1;
         netReady   = 1'b1;
      end
   endtask

   task automatic checkAndStep();
      logic expReady;
      logic netPending;
      expReady   = (expQ.size() == 0) || traceReady;
      netPending = (modelWanted != modelReported);
      checkFlag("retReady_o", retReady, expReady);
      checkFlag("traceValid_o", traceValid, expQ.size() != 0);
      if (expQ.size() != 0) begin
         checkTrace("trace_o", trace, expQ[0]);
      end
      checkFlag("netValid_o", netValid, netPending);
      if (netPending) begin
         checkNet("netEvent_o", netEvent, expectedNet());
      end
      retFire   = retValid && expReady;
      traceFire = (expQ.size() != 0) && traceReady;
      netFire   = netPending && netReady;
      stepModel(ret, retFire, traceFire, netFire, irq, debugReq);
      if (retFire) begin
         accepted = accepted + 1;
      end
   endtask

   function automatic logic allDone();
      return accepted >= numRet && !retValid && expQ.size() == 0
          && modelWanted == modelReported;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // main sequence
   //////////////////////////////////////////////////////////////////////
   initial begin
      rngState   = 32'hca9d4208;
      rstN       = 1'b0;
      retValid   = 1'b0;
      ret        = '0;
      traceReady = 1'b0;
      irq        = '0;
      debugReq   = 1'b0;
      netReady   = 1'b0;
      nextOrder  = '0;
      retFire    = 1'b0;
      traceFire  = 1'b0;
      netFire    = 1'b0;
      accepted   = 0;
      expQ.delete();
      modelWanted   = '0;
      modelReported = '0;
      modelNmiStore = 1'b0;
      for (int c = 0; c < rvviPkg::numCsr; c++) begin
         modelPrevCsr[c] = '0;
      end
      repeat (2) @(posedge rvvi);
      @(negedge rvvi);
      rstN = 1'b1;
      while (!allDone()) begin
         driveInputs();
         // let combinational outputs settle before sampling
         #1;
         checkAndStep();
         @(negedge rvvi);
      end
      checkFlag("traceValid_o", traceValid, 1'b0);
      checkFlag("netValid_o", netValid, 1'b0);
      $display(">>> PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+dv
common/rvviPkg.sv
design/retireFormatter.sv
netTracker/netLatch.sv
netTracker/netReporter.sv
design/rvfiRvviBridge.sv
dv/tbBridge.sv

/* Bender.yml */
package:
  name: rvfiRvviBridge

sources:
  - files:
      - common/rvviPkg.sv
      - design/retireFormatter.sv
      - netTracker/netLatch.sv
      - netTracker/netReporter.sv
      - design/rvfiRvviBridge.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tbBridge.sv
